// File: verilog.f
+incdir+include
src/usb_ctrl_pkg.sv
src/ctrl_req_if.sv
src/spi_xfer_if.sv
src/setup_capture.sv
src/ctrl_xfer_fsm.sv
src/spi_bridge.sv
src/usb_spi_ctrl_ep.sv
dv/usb_spi_ctrl_ep_assertions.sv
dv/usb_spi_ctrl_ep_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps -f verilog.f \
  --top-module usb_spi_ctrl_ep_tb -o usb_spi_ctrl_ep_sim &&
./obj_dir/usb_spi_ctrl_ep_sim | tee /dev/stderr | grep -F "*** TEST PASSED ***" > /dev/null &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed"; exit 1; }

// File: dv/usb_spi_ctrl_ep_tb.sv
`timescale 1ns/100ps
`default_nettype none

module usb_spi_ctrl_ep_tb;

  localparam int max_cycles = 4000; // tests need about 1500

  logic       clk = 1'b0;
  logic       reset;
  logic       out_ep_grant;
  logic       out_ep_data_avail;
  logic       out_ep_setup;
  logic [7:0] out_ep_data;
  logic       out_ep_acked;
  logic       in_ep_grant;
  logic       in_ep_data_free;
  logic       in_ep_acked;
  logic       spi_miso = 1'b1;
  wire        out_ep_req;
  wire        out_ep_data_get;
  wire        out_ep_stall;
  wire        in_ep_req;
  wire        in_ep_data_put;
  wire  [7:0] in_ep_data;
  wire        in_ep_data_done;
  wire        in_ep_stall;
  wire        spi_mosi;
  wire        spi_clk;
  wire        spi_csn;
  wire  [6:0] dev_addr;

  int          value_errors = 0;
  int          other_errors = 0;
  int          cycles = 0;
  string       phase = "reset";
  logic [31:0] rng_state;
  logic [7:0]  pkt_bytes [$];
  logic [7:0]  rx_bytes [$];
  logic [7:0]  written [$];
  logic [7:0]  mosi_seen [$];
  logic [7:0]  mosi_shift = 8'h00;
  int          mosi_bits = 0;

  // expected descriptor contents
  logic [7:0] device_desc [18] = '{
    8'd18, 8'h01, 8'h00, 8'h02, 8'hff, 8'h00, 8'h00, 8'd32, 8'hc0,
    8'h16, 8'hdc, 8'h05, 8'h01, 8'h00, 8'h00, 8'h00, 8'h00, 8'h01
  };
  logic [7:0] config_desc [9] = '{
    8'd9, 8'h02, 8'd18, 8'h00, 8'h01, 8'h01, 8'h00, 8'hc0, 8'd250
  };

  usb_spi_ctrl_ep UUT (
    .clk(clk), .reset(reset), .dev_addr(dev_addr),
    .spi_miso(spi_miso), .spi_mosi(spi_mosi), .spi_clk(spi_clk), .spi_csn(spi_csn),
    .out_ep_req(out_ep_req), .out_ep_grant(out_ep_grant),
    .out_ep_data_avail(out_ep_data_avail), .out_ep_setup(out_ep_setup),
    .out_ep_data_get(out_ep_data_get), .out_ep_data(out_ep_data),
    .out_ep_stall(out_ep_stall), .out_ep_acked(out_ep_acked),
    .in_ep_req(in_ep_req), .in_ep_grant(in_ep_grant), .in_ep_data_free(in_ep_data_free),
    .in_ep_data_put(in_ep_data_put), .in_ep_data(in_ep_data),
    .in_ep_data_done(in_ep_data_done), .in_ep_stall(in_ep_stall), .in_ep_acked(in_ep_acked)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout after %0d cycles, stuck in %s", cycles, phase);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  //////////////////////////////
  // spi chip model
  //////////////////////////////
  always @(spi_mosi) spi_miso = ~spi_mosi; // chip answers with inverted bits

  always @(posedge spi_clk) begin
    if (spi_csn === 1'b0) begin
      mosi_shift = {mosi_shift[6:0], spi_mosi}; // msb first
      mosi_bits  = mosi_bits + 1;
      if (mosi_bits == 8) begin
        mosi_seen.push_back(mosi_shift);
        mosi_bits = 0;
      end
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    value_errors = value_errors + 1;
    $display("FAIL t=%0t %s expected 0x%0h got 0x%0h", $time, name, expected, got);
  endtask

  task automatic report_problem(input string what);
    other_errors = other_errors + 1;
    $display("ERROR t=%0t %s: %s", $time, phase, what);
  endtask

  //////////////////////////////
  // endpoint model
  //////////////////////////////
  task automatic drive_out_packet(input logic setup_pkt);
    @(posedge clk);
    #1;
    out_ep_setup      = setup_pkt;
    out_ep_data_avail = 1'b1;
    out_ep_grant      = 1'b1;
    for (int i = 0; i < pkt_bytes.size(); i++) begin
      @(posedge clk);
      if (out_ep_req !== 1'b1 || out_ep_data_get !== 1'b1) begin
        report_problem("out_ep_req or out_ep_data_get is low while data is offered");
      end
      #1;
      out_ep_data = pkt_bytes[i]; // byte follows the grant cycle
      if (i == pkt_bytes.size() - 1) begin
        out_ep_data_avail = 1'b0;
        out_ep_grant      = 1'b0;
      end
    end
    @(posedge clk);
    #1;
    out_ep_setup = 1'b0;
  endtask

  task automatic send_setup(input logic [7:0] req_type, input logic [7:0] request,
                            input logic [15:0] value, input logic [15:0] index,
                            input logic [15:0] length);
    pkt_bytes = '{req_type, request, value[7:0], value[15:8],
                  index[7:0], index[15:8], length[7:0], length[15:8]};
    drive_out_packet(1'b1);
  endtask

  task automatic send_out_data(input int n);
    repeat (4) @(posedge clk); // host turnaround
    pkt_bytes.delete();
    for (int i = 0; i < n; i++) pkt_bytes.push_back(written[i]);
    drive_out_packet(1'b0);
  endtask

  task automatic read_in_data();
    logic done;
    done = 1'b0;
    rx_bytes.delete();
    while (!done) begin
      @(negedge clk);
      if (in_ep_data_put && in_ep_grant && in_ep_data_free) rx_bytes.push_back(in_ep_data);
      done = in_ep_data_done;
    end
  endtask

  task automatic wait_zlp();
    logic done;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (in_ep_data_put) report_problem("a byte was put in a zero-length status packet");
      done = in_ep_data_done;
    end
  endtask

  task automatic ack_in_packet();
    @(posedge clk);
    #1;
    in_ep_acked = 1'b1;
    @(posedge clk);
    #1;
    in_ep_acked = 1'b0;
  endtask

  task automatic ack_out_packet();
    @(posedge clk);
    #1;
    out_ep_acked = 1'b1;
    @(posedge clk);
    #1;
    out_ep_acked = 1'b0;
  endtask

  // host acks the in data, then sends a zero-length out
  task automatic status_after_in();
    ack_in_packet();
    ack_out_packet();
  endtask

  task automatic status_after_out();
    wait_zlp();
    ack_in_packet();
  endtask

  task automatic check_mosi(input int start, input int n);
    if (mosi_seen.size() - start != n) begin
      report_mismatch("mosi byte count", 32'(mosi_seen.size() - start), 32'(n));
    end else begin
      for (int i = 0; i < n; i++) begin
        if (mosi_seen[start + i] !== written[i]) begin
          report_mismatch($sformatf("mosi byte %0d", i), 32'(mosi_seen[start + i]),
                          32'(written[i]));
        end
      end
    end
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////
  task automatic check_reset_state();
    phase = "reset state";
    if (spi_clk !== 1'b1) report_mismatch("spi_clk", 32'(spi_clk), 32'd1);
    if (spi_csn !== 1'b1) report_mismatch("spi_csn", 32'(spi_csn), 32'd1);
    if (in_ep_req !== 1'b0) report_mismatch("in_ep_req", 32'(in_ep_req), 32'd0);
    if (in_ep_data_put !== 1'b0) report_mismatch("in_ep_data_put", 32'(in_ep_data_put), 32'd0);
    if (in_ep_data_done !== 1'b0) report_mismatch("in_ep_data_done", 32'(in_ep_data_done), 32'd0);
    if (in_ep_stall !== 1'b0) report_mismatch("in_ep_stall", 32'(in_ep_stall), 32'd0);
    if (dev_addr !== 7'h00) report_mismatch("dev_addr", 32'(dev_addr), 32'd0);
  endtask

  task automatic get_device_descriptor();
    phase = "device descriptor";
    send_setup(8'h80, 8'h06, 16'h0100, 16'h0000, 16'd64);
    read_in_data();
    if (rx_bytes.size() != 18) report_mismatch("in byte count", 32'(rx_bytes.size()), 32'd18);
    for (int i = 0; i < 18 && i < rx_bytes.size(); i++) begin
      if (rx_bytes[i] !== device_desc[i]) begin
        report_mismatch($sformatf("in_ep_data device byte %0d", i), 32'(rx_bytes[i]),
                        32'(device_desc[i]));
      end
    end
    status_after_in();
  endtask

  task automatic get_config_truncated();
    phase = "config descriptor";
    send_setup(8'h80, 8'h06, 16'h0200, 16'h0000, 16'd9); // shorter than the 18 available
    read_in_data();
    if (rx_bytes.size() != 9) report_mismatch("in byte count", 32'(rx_bytes.size()), 32'd9);
    for (int i = 0; i < 9 && i < rx_bytes.size(); i++) begin
      if (rx_bytes[i] !== config_desc[i]) begin
        report_mismatch($sformatf("in_ep_data config byte %0d", i), 32'(rx_bytes[i]),
                        32'(config_desc[i]));
      end
    end
    status_after_in();
  endtask

  task automatic set_address_after_status();
    phase = "set address";
    send_setup(8'h00, 8'h05, 16'h002a, 16'h0000, 16'd0);
    wait_zlp();
    if (dev_addr !== 7'h00) report_mismatch("dev_addr", 32'(dev_addr), 32'h00);
    ack_in_packet();
    @(negedge clk);
    if (dev_addr !== 7'h2a) report_mismatch("dev_addr", 32'(dev_addr), 32'h2a);
  endtask

  task automatic stall_device_qualifier();
    phase = "device qualifier";
    send_setup(8'h80, 8'h06, 16'h0600, 16'h0000, 16'd10);
    repeat (12) begin
      @(negedge clk);
      if (in_ep_data_put) report_problem("a byte was put while the endpoint is stalled");
    end
    if (in_ep_stall !== 1'b1) report_mismatch("in_ep_stall", 32'(in_ep_stall), 32'd1);
    if (out_ep_stall !== 1'b1) report_mismatch("out_ep_stall", 32'(out_ep_stall), 32'd1);
    get_device_descriptor();
    if (in_ep_stall !== 1'b0) report_mismatch("in_ep_stall", 32'(in_ep_stall), 32'd0);
    if (out_ep_stall !== 1'b0) report_mismatch("out_ep_stall", 32'(out_ep_stall), 32'd0);
  endtask

  task automatic vendor_out_to_spi();
    int start;
    phase = "vendor out";
    written.delete();
    for (int i = 0; i < 5; i++) begin
      rng_state = xorshift32(rng_state);
      written.push_back(rng_state[7:0]);
    end
    start = mosi_seen.size();
    send_setup(8'h40, 8'h01, 16'h0000, 16'h0000, 16'd5);
    send_out_data(5);
    if (spi_csn !== 1'b0) report_mismatch("spi_csn", 32'(spi_csn), 32'd0);
    status_after_out();
    while (spi_csn !== 1'b1) @(negedge clk);
    check_mosi(start, 5);
  endtask

  task automatic vendor_in_and_keep_open();
    logic [7:0] expected;
    int         start;
    phase = "vendor in";
    send_setup(8'hc0, 8'h02, 16'h0000, 16'h0000, 16'd5);
    read_in_data();
    if (rx_bytes.size() != 5) report_mismatch("in byte count", 32'(rx_bytes.size()), 32'd5);
    for (int i = 0; i < 5 && i < rx_bytes.size(); i++) begin
      expected = ~written[i]; // chip model inverts
      if (rx_bytes[i] !== expected) begin
        report_mismatch($sformatf("in_ep_data read-back byte %0d", i), 32'(rx_bytes[i]),
                        32'(expected));
      end
    end
    status_after_in();

    phase = "keep open";
    start = mosi_seen.size();
    send_setup(8'h40, 8'h01, 16'h0001, 16'h0000, 16'd3); // wValue bit 0 holds chip select
    send_out_data(3);
    status_after_out();
    repeat (20) @(negedge clk);
    if (spi_csn !== 1'b0) report_mismatch("spi_csn", 32'(spi_csn), 32'd0);
    check_mosi(start, 3);
  endtask

  initial begin
    int assert_fails;
    reset             = 1'b1;
    out_ep_grant      = 1'b0;
    out_ep_data_avail = 1'b0;
    out_ep_setup      = 1'b0;
    out_ep_data       = 8'h00;
    out_ep_acked      = 1'b0;
    in_ep_grant       = 1'b1; // host side always ready
    in_ep_data_free   = 1'b1;
    in_ep_acked       = 1'b0;
    rng_state         = 32'd72;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    check_reset_state();
    get_device_descriptor();
    get_config_truncated();
    set_address_after_status();
    stall_device_qualifier();
    vendor_out_to_spi();
    vendor_in_and_keep_open();

    repeat (2) @(posedge clk);
    assert_fails = int'(UUT.u_assertions.fail_count);
    $display("value errors %0d, other errors %0d, assertion failures %0d",
             value_errors, other_errors, assert_fails);
    if (value_errors + other_errors + assert_fails == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/usb_spi_ctrl_ep_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module usb_spi_ctrl_ep_assertions (
  input wire clk,
  input wire reset,
  input wire in_ep_data_put,
  input wire in_ep_stall,
  input wire in_ep_data_done,
  input wire spi_clk,
  input wire spi_csn
);

  int unsigned fail_count = 0;  // read by the testbench at the end

  no_put_while_stalled: assert property (
    @(posedge clk) disable iff (reset) !(in_ep_data_put && in_ep_stall)
  ) else begin
    $error("in_ep_data_put is high while in_ep_stall is high");
    fail_count = fail_count + 1;
  end

  // idle spi clock level is high
  spi_clk_high_when_idle: assert property (
    @(posedge clk) disable iff (reset) spi_csn |-> spi_clk
  ) else begin
    $error("spi_clk is low while spi_csn is high");
    fail_count = fail_count + 1;
  end

  done_is_one_cycle: assert property (
    @(posedge clk) disable iff (reset) in_ep_data_done |=> !in_ep_data_done
  ) else begin
    $error("in_ep_data_done stayed high for more than one cycle");
    fail_count = fail_count + 1;
  end

endmodule

bind usb_spi_ctrl_ep usb_spi_ctrl_ep_assertions u_assertions (
  .clk(clk),
  .reset(reset),
  .in_ep_data_put(in_ep_data_put),
  .in_ep_stall(in_ep_stall),
  .in_ep_data_done(in_ep_data_done),
  .spi_clk(spi_clk),
  .spi_csn(spi_csn)
);

`default_nettype wire

// File: src/usb_spi_ctrl_ep.sv
`timescale 1ns/100ps
`default_nettype none

module usb_spi_ctrl_ep (
  input  wire        clk,
  input  wire        reset,
  output wire  [6:0] dev_addr,

  // spi chip
  input  wire        spi_miso,
  output wire        spi_mosi,
  output wire        spi_clk,
  output wire        spi_csn,

  // out endpoint
  output wire        out_ep_req,
  input  wire        out_ep_grant,
  input  wire        out_ep_data_avail,
  input  wire        out_ep_setup,
  output wire        out_ep_data_get,
  input  wire  [7:0] out_ep_data,
  output wire        out_ep_stall,
  input  wire        out_ep_acked,

  // in endpoint
  output wire        in_ep_req,
  input  wire        in_ep_grant,
  input  wire        in_ep_data_free,
  output wire        in_ep_data_put,
  output wire  [7:0] in_ep_data,
  output wire        in_ep_data_done,
  output wire        in_ep_stall,
  input  wire        in_ep_acked
);

  ctrl_req_if req_bus ();
  spi_xfer_if spi_bus ();

  //////////////////////////////
  // stage 1, setup capture
  //////////////////////////////
  setup_capture u_setup_capture (
    .clk(clk), .reset(reset),
    .out_ep_data_avail(out_ep_data_avail), .out_ep_grant(out_ep_grant),
    .out_ep_setup(out_ep_setup), .out_ep_data(out_ep_data),
    .out_ep_req(out_ep_req), .out_ep_data_get(out_ep_data_get),
    .req(req_bus.capture)
  );

  //////////////////////////////
  // stage 2, transfer control
  //////////////////////////////
  ctrl_xfer_fsm u_ctrl_xfer_fsm (
    .clk(clk), .reset(reset),
    .req(req_bus.ctrl), .spi(spi_bus.ctrl),
    .in_ep_grant(in_ep_grant), .in_ep_data_free(in_ep_data_free),
    .in_ep_acked(in_ep_acked), .out_ep_acked(out_ep_acked),
    .in_ep_req(in_ep_req), .in_ep_data_put(in_ep_data_put),
    .in_ep_data(in_ep_data), .in_ep_data_done(in_ep_data_done),
    .in_ep_stall(in_ep_stall), .out_ep_stall(out_ep_stall),
    .dev_addr(dev_addr)
  );

  //////////////////////////////
  // stage 3, spi bridge
  //////////////////////////////
  spi_bridge u_spi_bridge (
    .clk(clk), .reset(reset),
    .spi(spi_bus.bridge),
    .spi_miso(spi_miso), .spi_mosi(spi_mosi),
    .spi_clk(spi_clk), .spi_csn(spi_csn)
  );

endmodule

`default_nettype wire

// File: src/spi_bridge.sv
`timescale 1ns/100ps
`default_nettype none
`include "usb_ctrl_settings.svh"

module spi_bridge (
  input  wire        clk,
  input  wire        reset,
  spi_xfer_if.bridge spi,
  input  wire        spi_miso,
  output logic       spi_mosi,
  output logic       spi_clk,
  output logic       spi_csn
);

  localparam int cnt_w  = $clog2(`USB_SPI_BUF_DEPTH + 1);
  localparam int buf_aw = $clog2(`USB_SPI_BUF_DEPTH);

  logic [7:0]       out_buf [`USB_SPI_BUF_DEPTH];
  logic [7:0]       in_buf  [`USB_SPI_BUF_DEPTH];
  logic [cnt_w-1:0] wr_ptr;    // bytes received from usb
  logic [cnt_w-1:0] done_cnt;  // bytes fully shifted
  logic [cnt_w-1:0] len_q;
  logic             keep_q;
  logic             active;    // shifting a byte
  logic [3:0]       half;      // spi_clk half period
  logic [7:0]       mosi_byte;
  logic [7:0]       miso_byte;

  wire [7:0] miso_next    = {miso_byte[6:0], spi_miso}; // msb arrives first
  wire       byte_waiting = done_cnt != wr_ptr;
  wire       wr_take      = spi.wr_en & (wr_ptr < len_q);

  assign spi_mosi    = mosi_byte[7];
  assign spi.rd_data = in_buf[spi.rd_addr];
  assign spi.busy    = byte_waiting;

  //////////////////////////////
  // counters and pins
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      done_cnt <= '0;
      len_q    <= '0;
      keep_q   <= 1'b0;
      active   <= 1'b0;
      half     <= '0;
      spi_clk  <= 1'b1;
      spi_csn  <= 1'b1;
    end else if (spi.start) begin
      wr_ptr   <= '0;
      done_cnt <= '0;
      len_q    <= spi.length;
      keep_q   <= spi.keep_open;
      active   <= 1'b0;
      spi_clk  <= 1'b1;
      spi_csn  <= 1'b0; // select chip for the whole request
    end else begin
      if (wr_take) wr_ptr <= wr_ptr + cnt_w'(1);
      if (active) begin
        half    <= half + 4'd1;
        spi_clk <= half[0]; // even half falls, odd half rises
        if (half == 4'd15) begin
          active   <= 1'b0;
          done_cnt <= done_cnt + cnt_w'(1);
        end
      end else if (byte_waiting) begin
        active <= 1'b1; // one skip cycle before the first edge
        half   <= '0;
      end else if (done_cnt == len_q && !keep_q) begin
        spi_csn <= 1'b1;
        spi_clk <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // shift registers and buffers
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (wr_take) out_buf[wr_ptr[buf_aw-1:0]] <= spi.wr_data;
    if (active && !half[0]) begin
      // falling edge, present next mosi bit
      mosi_byte <= (half == 4'd0) ? out_buf[done_cnt[buf_aw-1:0]] : {mosi_byte[6:0], 1'b0};
    end
    if (active && half[0]) begin
      miso_byte <= miso_next; // rising edge sample
      if (half == 4'd15) in_buf[done_cnt[buf_aw-1:0]] <= miso_next;
    end
  end

endmodule

`default_nettype wire

// File: src/ctrl_xfer_fsm.sv
`timescale 1ns/100ps
`default_nettype none
`include "usb_ctrl_settings.svh"

module ctrl_xfer_fsm (
  input  wire        clk,
  input  wire        reset,
  ctrl_req_if.ctrl   req,
  spi_xfer_if.ctrl   spi,
  input  wire        in_ep_grant,
  input  wire        in_ep_data_free,
  input  wire        in_ep_acked,
  input  wire        out_ep_acked,
  output logic       in_ep_req,
  output logic       in_ep_data_put,
  output logic [7:0] in_ep_data,
  output logic       in_ep_data_done,
  output logic       in_ep_stall,
  output logic       out_ep_stall,
  output logic [6:0] dev_addr
);

  localparam int cnt_w  = $clog2(`USB_SPI_BUF_DEPTH + 1);
  localparam int buf_aw = $clog2(`USB_SPI_BUF_DEPTH);
  localparam int rom_aw = $clog2(`USB_DESC_ROM_DEPTH);

  localparam logic [7:0] desc_rom [`USB_DESC_ROM_DEPTH] = '{
    8'd18, 8'h01, 8'h00, 8'h02,  // device descriptor, usb 2.0
    8'hff, 8'h00, 8'h00, 8'd32,  // vendor class, ep0 packet 32
    8'hc0, 8'h16, 8'hdc, 8'h05,  // vendor and product id
    8'h01, 8'h00, 8'h00, 8'h00,  // release 0.01, no strings
    8'h00, 8'h01,                // one configuration
    8'd9,  8'h02, 8'd18, 8'h00,  // config descriptor, total 18
    8'h01, 8'h01, 8'h00, 8'hc0,  // one interface, self powered
    8'd250,                      // 500 mA
    8'd9,  8'h04, 8'h00, 8'h00,  // interface 0, ep0 only
    8'h00, 8'h00, 8'h00, 8'h00, 8'h00
  };

  usb_ctrl_pkg::ctrl_state_e state, state_next;
  logic [rom_aw-1:0] rom_base, desc_base;
  logic [cnt_w-1:0]  xfer_len, desc_len;
  logic [cnt_w-1:0]  sent;          // bytes handed to the in endpoint
  logic              desc_stall;
  logic              use_buf;       // in data comes from spi read-back
  logic              spi_wr_ok;     // vendor out data goes to the bridge
  logic              zlp_pending;
  logic              addr_pending;
  logic [6:0]        new_addr;
  logic              start_q;

  wire [7:0]  req_type = req.setup.fields.req_type;
  wire [7:0]  request  = req.setup.fields.request;
  wire [15:0] w_value  = req.setup.fields.value;
  wire [15:0] w_length = req.setup.fields.length;

  wire is_vendor   = req_type[6:5] != 2'd0;
  wire dir_in      = req_type[7];
  wire has_data    = w_length != 16'd0;
  wire vendor_out  = is_vendor & has_data & ~dir_in;
  wire is_set_addr = ~is_vendor & (request == usb_ctrl_pkg::req_set_address);

  wire byte_move     = in_ep_data_put & in_ep_grant;
  wire last_move     = byte_move & ((sent + cnt_w'(1)) == xfer_len);
  wire send_zlp      = zlp_pending & ~spi.busy; // wait for spi to drain
  wire status_in_end = (state == usb_ctrl_pkg::ctrl_status_in) & in_ep_acked;
  wire [rom_aw-1:0] rom_addr = rom_base + rom_aw'(sent);

  assign in_ep_req      = (state == usb_ctrl_pkg::ctrl_data_in) && (sent != xfer_len);
  assign in_ep_data_put = in_ep_req & in_ep_data_free;
  assign in_ep_data     = use_buf ? spi.rd_data : desc_rom[rom_addr];
  assign out_ep_stall   = in_ep_stall; // stall covers the whole control pipe

  assign spi.start     = start_q;
  assign spi.length    = xfer_len;
  assign spi.keep_open = w_value[0];
  assign spi.wr_en     = spi_wr_ok & (state == usb_ctrl_pkg::ctrl_data_out) & req.data_valid;
  assign spi.wr_data   = req.data;
  assign spi.rd_addr   = sent[buf_aw-1:0];

  //////////////////////////////
  // request decode
  //////////////////////////////
  always_comb begin
    desc_base  = '0;
    desc_len   = '0;
    desc_stall = 1'b0;
    if (is_vendor) begin
      desc_len = cnt_w'(`USB_SPI_BUF_DEPTH);
    end else if (request == usb_ctrl_pkg::req_get_descriptor) begin
      case (w_value[15:8])
        usb_ctrl_pkg::desc_device: desc_len = cnt_w'(`USB_DESC_CONFIG_BASE);
        usb_ctrl_pkg::desc_config: begin
          desc_base = rom_aw'(`USB_DESC_CONFIG_BASE);
          desc_len  = cnt_w'(`USB_DESC_ROM_DEPTH - `USB_DESC_CONFIG_BASE);
        end
        usb_ctrl_pkg::desc_qualifier: desc_stall = 1'b1; // full speed only
        default: desc_stall = 1'b1;                      // no string descriptors
      endcase
    end else if (request == usb_ctrl_pkg::req_set_configuration) begin
      desc_stall = w_value[7:0] > 8'd1; // only configuration 1 exists
    end
  end

  //////////////////////////////
  // transfer state machine
  //////////////////////////////
  always_comb begin
    state_next = state;
    case (state)
      usb_ctrl_pkg::ctrl_setup: begin
        if (desc_stall) state_next = usb_ctrl_pkg::ctrl_idle;
        else if (has_data && dir_in) state_next = usb_ctrl_pkg::ctrl_data_in;
        else if (has_data) state_next = usb_ctrl_pkg::ctrl_data_out;
        else state_next = usb_ctrl_pkg::ctrl_status_in;
      end
      usb_ctrl_pkg::ctrl_data_in: begin
        if (in_ep_acked && sent == xfer_len) state_next = usb_ctrl_pkg::ctrl_status_out;
      end
      usb_ctrl_pkg::ctrl_data_out: begin
        if (req.pkt_end) state_next = usb_ctrl_pkg::ctrl_status_in;
      end
      usb_ctrl_pkg::ctrl_status_in: begin
        if (in_ep_acked) state_next = usb_ctrl_pkg::ctrl_idle;
      end
      usb_ctrl_pkg::ctrl_status_out: begin
        if (out_ep_acked) state_next = usb_ctrl_pkg::ctrl_idle;
      end
      default: state_next = usb_ctrl_pkg::ctrl_idle;
    endcase
    if (req.setup_done) state_next = usb_ctrl_pkg::ctrl_setup; // setup always restarts
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state           <= usb_ctrl_pkg::ctrl_idle;
      rom_base        <= '0;
      xfer_len        <= '0;
      sent            <= '0;
      use_buf         <= 1'b0;
      spi_wr_ok       <= 1'b0;
      zlp_pending     <= 1'b0;
      addr_pending    <= 1'b0;
      start_q         <= 1'b0;
      in_ep_stall     <= 1'b0;
      in_ep_data_done <= 1'b0;
      dev_addr        <= '0;
    end else begin
      state           <= state_next;
      start_q         <= 1'b0;
      in_ep_data_done <= send_zlp | last_move;
      if (byte_move) sent <= sent + cnt_w'(1);
      if (send_zlp) zlp_pending <= 1'b0;
      if (req.setup_done) in_ep_stall <= 1'b0;
      if (state == usb_ctrl_pkg::ctrl_setup) begin
        rom_base     <= desc_base;
        xfer_len     <= (w_length < 16'(desc_len)) ? w_length[cnt_w-1:0] : desc_len;
        sent         <= '0;
        use_buf      <= is_vendor;
        spi_wr_ok    <= vendor_out;
        start_q      <= vendor_out;
        in_ep_stall  <= desc_stall;
        zlp_pending  <= ~desc_stall & (~has_data | (dir_in & (desc_len == '0)));
        addr_pending <= is_set_addr;
      end
      if (state == usb_ctrl_pkg::ctrl_data_out && req.pkt_end) zlp_pending <= 1'b1;
      if (status_in_end && addr_pending) begin
        dev_addr     <= new_addr; // status went out on the old address
        addr_pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == usb_ctrl_pkg::ctrl_setup) new_addr <= w_value[6:0];
  end

endmodule

`default_nettype wire

// File: src/setup_capture.sv
`timescale 1ns/100ps
`default_nettype none

module setup_capture (
  input  wire        clk,
  input  wire        reset,
  input  wire        out_ep_data_avail,
  input  wire        out_ep_grant,
  input  wire        out_ep_setup,
  input  wire  [7:0] out_ep_data,
  output logic       out_ep_req,
  output logic       out_ep_data_get,
  ctrl_req_if.capture req
);

  logic                     avail_q;
  logic                     byte_valid;  // out_ep_data holds a byte this cycle
  logic                     is_setup;    // current packet is a setup packet
  logic [2:0]               byte_idx;
  usb_ctrl_pkg::setup_pkt_u setup_q;

  wire pkt_start = out_ep_data_avail & ~avail_q;
  wire pkt_fall  = ~out_ep_data_avail & avail_q;

  // take every byte the endpoint offers
  assign out_ep_req      = out_ep_data_avail;
  assign out_ep_data_get = out_ep_data_avail;

  assign req.setup      = setup_q;
  assign req.data       = out_ep_data;
  assign req.data_valid = byte_valid & ~is_setup;

  always_ff @(posedge clk) begin
    if (reset) begin
      avail_q        <= 1'b0;
      byte_valid     <= 1'b0;
      is_setup       <= 1'b0;
      byte_idx       <= '0;
      req.setup_done <= 1'b0;
      req.pkt_end    <= 1'b0;
    end else begin
      avail_q        <= out_ep_data_avail;
      byte_valid     <= out_ep_data_avail & out_ep_grant;
      req.setup_done <= pkt_fall & is_setup;
      req.pkt_end    <= pkt_fall & ~is_setup;
      if (pkt_start) begin
        is_setup <= out_ep_setup;
        if (out_ep_setup) begin
          byte_idx <= '0; // restart at bmRequestType
        end
      end else if (byte_valid && is_setup) begin
        byte_idx <= byte_idx + 3'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (byte_valid && is_setup) begin
      setup_q.bytes[byte_idx] <= out_ep_data;
    end
  end

endmodule

`default_nettype wire

// File: src/spi_xfer_if.sv
`timescale 1ns/100ps
`default_nettype none
`include "usb_ctrl_settings.svh"

interface spi_xfer_if;
  logic                                      start;      // pulse, new vendor out
  logic [$clog2(`USB_SPI_BUF_DEPTH + 1)-1:0] length;     // bytes expected
  logic                                      keep_open;  // hold csn low when done
  logic                                      wr_en;      // append to out buffer
  logic [7:0]                                wr_data;
  logic [$clog2(`USB_SPI_BUF_DEPTH)-1:0]     rd_addr;    // in buffer read index
  logic [7:0]                                rd_data;
  logic                                      busy;       // bytes still to shift

  modport ctrl (
    output start, length, keep_open, wr_en, wr_data, rd_addr,
    input  rd_data, busy
  );

  modport bridge (
    input  start, length, keep_open, wr_en, wr_data, rd_addr,
    output rd_data, busy
  );
endinterface

`default_nettype wire

// File: src/ctrl_req_if.sv
`timescale 1ns/100ps
`default_nettype none

interface ctrl_req_if;
  logic                     setup_done;  // pulse, setup packet complete
  usb_ctrl_pkg::setup_pkt_u setup;       // held until next setup
  logic                     data_valid;  // non-setup out byte
  logic [7:0]               data;
  logic                     pkt_end;     // pulse, out data packet complete

  modport capture (
    output setup_done, setup, data_valid, data, pkt_end
  );

  modport ctrl (
    input setup_done, setup, data_valid, data, pkt_end
  );
endinterface

`default_nettype wire

// File: src/usb_ctrl_pkg.sv
`default_nettype none

package usb_ctrl_pkg;

  //////////////////////////////
  // setup packet
  //////////////////////////////

  // one 8-byte setup packet, filled by byte index and read by field
  typedef union packed {
    logic [7:0][7:0] bytes;    // bytes[0] is the first byte on the wire
    struct packed {
      logic [15:0] length;     // wLength
      logic [15:0] index;      // wIndex
      logic [15:0] value;      // wValue
      logic [7:0]  request;    // bRequest
      logic [7:0]  req_type;   // bmRequestType
    } fields;
  } setup_pkt_u;

  typedef enum logic [2:0] {
    ctrl_idle,
    ctrl_setup,
    ctrl_data_in,
    ctrl_data_out,
    ctrl_status_in,
    ctrl_status_out
  } ctrl_state_e;

  //////////////////////////////
  // standard request codes
  //////////////////////////////
  localparam logic [7:0] req_set_address       = 8'h05;
  localparam logic [7:0] req_get_descriptor    = 8'h06;
  localparam logic [7:0] req_set_configuration = 8'h09;

  // descriptor types, high byte of wValue
  localparam logic [7:0] desc_device    = 8'h01;
  localparam logic [7:0] desc_config    = 8'h02;
  localparam logic [7:0] desc_qualifier = 8'h06;

endpackage

`default_nettype wire

// File: include/usb_ctrl_settings.svh
`ifndef USB_CTRL_SETTINGS_SVH
`define USB_CTRL_SETTINGS_SVH

// bytes held in each spi buffer, one ep0 packet
`define USB_SPI_BUF_DEPTH 32

// descriptor rom, device descriptor first
`define USB_DESC_ROM_DEPTH 36
`define USB_DESC_CONFIG_BASE 18  // also the device descriptor length

`endif
